/* la_params.svh */
`ifndef LA_PARAMS_SVH
`define LA_PARAMS_SVH

`define LA_RESET_PC     32'h1c00_0000
`define LA_NUM_ALU_OPS  12
`define LA_ZERO_REG     5'd0

// bit positions inside the one-hot alu operation
`define LA_ALU_ADD      0
`define LA_ALU_SUB      1
`define LA_ALU_SLT      2
`define LA_ALU_SLTU     3
`define LA_ALU_AND      4
`define LA_ALU_NOR      5
`define LA_ALU_OR       6
`define LA_ALU_XOR      7
`define LA_ALU_SLL      8
`define LA_ALU_SRL      9
`define LA_ALU_SRA      10
`define LA_ALU_LUI      11

`endif

/* la_pkg.sv */
`include "la_params.svh"

package la_pkg;

    // data, address or instruction word
    typedef logic [31:0] word_t;

    typedef logic [4:0] reg_idx_t;

    // one bit per alu operation, at most one set
    typedef logic [`LA_NUM_ALU_OPS-1:0] alu_op_t;

    // one instruction at a time, unused steps skipped
    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_exec,
        st_mem,
        st_wb
    } state_t;

endpackage

/* la_decoder.sv */
`include "la_params.svh"

module la_decoder (
    input  la_pkg::word_t    inst,
    input  la_pkg::word_t    pc,
    output la_pkg::alu_op_t  alu_op,
    output la_pkg::reg_idx_t rf_raddr1,
    output la_pkg::reg_idx_t rf_raddr2,
    output la_pkg::reg_idx_t dest,
    output logic             src1_is_pc,
    output logic             src2_is_imm,
    output la_pkg::word_t    imm,
    output logic             is_load,
    output logic             is_store,
    output logic             gr_we,
    output logic             is_cond_branch,
    output logic             branch_on_eq,
    output logic             is_jump,
    output logic             is_jirl,
    output la_pkg::word_t    branch_target_offs
);

    la_pkg::reg_idx_t rd;
    la_pkg::reg_idx_t rj;
    la_pkg::reg_idx_t rk;

    logic aligned;
    logic grp_3r;
    logic grp_shift;

    logic inst_add_w;
    logic inst_sub_w;
    logic inst_slt;
    logic inst_sltu;
    logic inst_nor;
    logic inst_and;
    logic inst_or;
    logic inst_xor;
    logic inst_slli_w;
    logic inst_srli_w;
    logic inst_srai_w;
    logic inst_addi_w;
    logic inst_lu12i_w;
    logic inst_ld_w;
    logic inst_st_w;
    logic inst_jirl;
    logic inst_b;
    logic inst_bl;
    logic inst_beq;
    logic inst_bne;

    logic need_ui5;
    logic need_si20;
    logic need_si26;
    logic src2_is_4;

    assign rd = inst[4:0];
    assign rj = inst[9:5];
    assign rk = inst[14:10];

    // a jirl to a misaligned target fetches nothing we can execute
    assign aligned   = (pc[1:0] == 2'b00);
    assign grp_3r    = aligned && (inst[31:20] == 12'h001);
    assign grp_shift = aligned && (inst[31:20] == 12'h004);

    assign inst_add_w   = grp_3r && (inst[19:15] == 5'h00);
    assign inst_sub_w   = grp_3r && (inst[19:15] == 5'h02);
    assign inst_slt     = grp_3r && (inst[19:15] == 5'h04);
    assign inst_sltu    = grp_3r && (inst[19:15] == 5'h05);
    assign inst_nor     = grp_3r && (inst[19:15] == 5'h08);
    assign inst_and     = grp_3r && (inst[19:15] == 5'h09);
    assign inst_or      = grp_3r && (inst[19:15] == 5'h0a);
    assign inst_xor     = grp_3r && (inst[19:15] == 5'h0b);
    assign inst_slli_w  = grp_shift && (inst[19:15] == 5'h01);
    assign inst_srli_w  = grp_shift && (inst[19:15] == 5'h09);
    assign inst_srai_w  = grp_shift && (inst[19:15] == 5'h11);
    assign inst_addi_w  = aligned && (inst[31:22] == 10'h00a);
    assign inst_ld_w    = aligned && (inst[31:22] == 10'h0a2);
    assign inst_st_w    = aligned && (inst[31:22] == 10'h0a6);
    assign inst_lu12i_w = aligned && (inst[31:25] == 7'h0a);   // bit 25 clear
    assign inst_jirl    = aligned && (inst[31:26] == 6'h13);
    assign inst_b       = aligned && (inst[31:26] == 6'h14);
    assign inst_bl      = aligned && (inst[31:26] == 6'h15);
    assign inst_beq     = aligned && (inst[31:26] == 6'h16);
    assign inst_bne     = aligned && (inst[31:26] == 6'h17);

    // address math of loads, stores and links goes through the adder
    assign alu_op[`LA_ALU_ADD]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                                | inst_jirl | inst_bl;
    assign alu_op[`LA_ALU_SUB]  = inst_sub_w;
    assign alu_op[`LA_ALU_SLT]  = inst_slt;
    assign alu_op[`LA_ALU_SLTU] = inst_sltu;
    assign alu_op[`LA_ALU_AND]  = inst_and;
    assign alu_op[`LA_ALU_NOR]  = inst_nor;
    assign alu_op[`LA_ALU_OR]   = inst_or;
    assign alu_op[`LA_ALU_XOR]  = inst_xor;
    assign alu_op[`LA_ALU_SLL]  = inst_slli_w;
    assign alu_op[`LA_ALU_SRL]  = inst_srli_w;
    assign alu_op[`LA_ALU_SRA]  = inst_srai_w;
    assign alu_op[`LA_ALU_LUI]  = inst_lu12i_w;

    assign need_ui5  = inst_slli_w | inst_srli_w | inst_srai_w;
    assign need_si20 = inst_lu12i_w;
    assign need_si26 = inst_b | inst_bl;
    assign src2_is_4 = inst_jirl | inst_bl;   // link value is pc + 4

    assign imm = src2_is_4 ? 32'd4 :
                 need_si20 ? {inst[24:5], 12'b0} :
                 need_ui5  ? {27'b0, inst[14:10]} :
                             {{20{inst[21]}}, inst[21:10]};

    assign branch_target_offs = need_si26 ? {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0}
                                          : {{14{inst[25]}}, inst[25:10], 2'b0};

    assign rf_raddr1 = rj;
    assign rf_raddr2 = (inst_beq | inst_bne | inst_st_w) ? rd : rk;
    assign dest      = inst_bl ? 5'd1 : rd;

    assign src1_is_pc  = inst_jirl | inst_bl;
    assign src2_is_imm = need_ui5 | inst_addi_w | inst_ld_w | inst_st_w | need_si20
                       | src2_is_4;

    assign is_load  = inst_ld_w;
    assign is_store = inst_st_w;
    assign gr_we    = grp_3r & (|alu_op) | need_ui5 | inst_addi_w | inst_lu12i_w
                    | inst_ld_w | inst_jirl | inst_bl;

    assign is_cond_branch = inst_beq | inst_bne;
    assign branch_on_eq   = inst_beq;
    assign is_jump        = inst_b | inst_bl | inst_jirl;
    assign is_jirl        = inst_jirl;

endmodule

/* la_alu.sv */
`include "la_params.svh"

module la_alu (
    input  la_pkg::alu_op_t alu_op,
    input  la_pkg::word_t   src1,
    input  la_pkg::word_t   src2,
    output la_pkg::word_t   result
);

    la_pkg::word_t add_res;
    la_pkg::word_t sub_res;
    la_pkg::word_t slt_res;
    la_pkg::word_t sltu_res;
    la_pkg::word_t sll_res;
    la_pkg::word_t srl_res;
    la_pkg::word_t sra_res;
    logic [4:0]    shamt;

    assign shamt = src2[4:0];

    assign add_res  = src1 + src2;
    assign sub_res  = src1 - src2;
    assign slt_res  = {31'b0, $signed(src1) < $signed(src2)};
    assign sltu_res = {31'b0, src1 < src2};
    assign sll_res  = src1 << shamt;
    assign srl_res  = src1 >> shamt;
    assign sra_res  = la_pkg::word_t'($signed(src1) >>> shamt);

    // one-hot select, nothing selected gives zero
    always_comb begin
        result = '0;
        if (alu_op[`LA_ALU_ADD])  result = result | add_res;
        if (alu_op[`LA_ALU_SUB])  result = result | sub_res;
        if (alu_op[`LA_ALU_SLT])  result = result | slt_res;
        if (alu_op[`LA_ALU_SLTU]) result = result | sltu_res;
        if (alu_op[`LA_ALU_AND])  result = result | (src1 & src2);
        if (alu_op[`LA_ALU_NOR])  result = result | ~(src1 | src2);
        if (alu_op[`LA_ALU_OR])   result = result | (src1 | src2);
        if (alu_op[`LA_ALU_XOR])  result = result | (src1 ^ src2);
        if (alu_op[`LA_ALU_SLL])  result = result | sll_res;
        if (alu_op[`LA_ALU_SRL])  result = result | srl_res;
        if (alu_op[`LA_ALU_SRA])  result = result | sra_res;
        if (alu_op[`LA_ALU_LUI])  result = result | src2;   // imm already shifted
    end

endmodule

/* la_regfile.sv */
`include "la_params.svh"

module la_regfile (
    input  logic             clk,
    input  la_pkg::reg_idx_t raddr1,
    input  la_pkg::reg_idx_t raddr2,
    input  logic             we,
    input  la_pkg::reg_idx_t waddr,
    input  la_pkg::word_t    wdata,
    output la_pkg::word_t    rdata1,
    output la_pkg::word_t    rdata2
);

    la_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (we && (waddr != `LA_ZERO_REG)) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired, never read from the array
    assign rdata1 = (raddr1 == `LA_ZERO_REG) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == `LA_ZERO_REG) ? '0 : regs[raddr2];

endmodule

/* la_control.sv */
`include "la_params.svh"

module la_control (
    input  logic             clk,
    input  logic             reset,
    input  la_pkg::word_t    inst_sram_rdata,
    input  la_pkg::word_t    data_sram_rdata,
    input  la_pkg::alu_op_t  alu_op,
    input  la_pkg::reg_idx_t dest,
    input  logic             src1_is_pc,
    input  logic             src2_is_imm,
    input  la_pkg::word_t    imm,
    input  logic             is_load,
    input  logic             is_store,
    input  logic             gr_we,
    input  logic             is_cond_branch,
    input  logic             branch_on_eq,
    input  logic             is_jump,
    input  logic             is_jirl,
    input  la_pkg::word_t    branch_target_offs,
    input  la_pkg::word_t    rf_rdata1,
    input  la_pkg::word_t    rf_rdata2,
    input  la_pkg::word_t    alu_result,
    output la_pkg::word_t    inst_sram_addr,
    output logic             data_sram_we,
    output la_pkg::word_t    data_sram_addr,
    output la_pkg::word_t    data_sram_wdata,
    output la_pkg::word_t    decode_inst,
    output la_pkg::word_t    decode_pc,
    output la_pkg::alu_op_t  alu_op_q,
    output la_pkg::word_t    alu_src1,
    output la_pkg::word_t    alu_src2,
    output logic             rf_we,
    output la_pkg::reg_idx_t rf_waddr,
    output la_pkg::word_t    rf_wdata,
    output la_pkg::word_t    debug_wb_pc,
    output logic [3:0]       debug_wb_rf_we,
    output la_pkg::reg_idx_t debug_wb_rf_wnum,
    output la_pkg::word_t    debug_wb_rf_wdata
);

    la_pkg::state_t   state;
    la_pkg::state_t   state_next;
    la_pkg::word_t    pc;
    la_pkg::word_t    pc_next;
    la_pkg::word_t    br_target;
    logic             br_taken;

    la_pkg::word_t    inst_pc_q;       // pc of the instruction in flight
    la_pkg::word_t    store_data_q;
    la_pkg::word_t    mem_data_q;
    la_pkg::reg_idx_t dest_q;
    logic             gr_we_q;
    logic             is_load_q;
    logic             is_store_q;

    always_comb begin
        state_next = state;
        case (state)
            la_pkg::st_fetch:  state_next = la_pkg::st_decode;
            // branches, b and unknown words end here
            la_pkg::st_decode: state_next = (gr_we || is_store) ? la_pkg::st_exec
                                                                : la_pkg::st_fetch;
            la_pkg::st_exec: begin
                if (is_load_q)
                    state_next = la_pkg::st_mem;
                else if (is_store_q)
                    state_next = la_pkg::st_fetch;
                else
                    state_next = la_pkg::st_wb;
            end
            la_pkg::st_mem:    state_next = la_pkg::st_wb;
            default:           state_next = la_pkg::st_fetch;
        endcase
    end

    // branch resolution in decode, rd sits on read port 2
    assign br_taken  = is_jump || (is_cond_branch && ((rf_rdata1 == rf_rdata2) == branch_on_eq));
    assign br_target = (is_jirl ? rf_rdata1 : pc) + branch_target_offs;
    assign pc_next   = br_taken ? br_target : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= la_pkg::st_fetch;
            pc         <= `LA_RESET_PC;
            alu_op_q   <= '0;
            gr_we_q    <= 1'b0;
            is_load_q  <= 1'b0;
            is_store_q <= 1'b0;
        end else begin
            state <= state_next;
            if (state == la_pkg::st_decode) begin
                pc         <= pc_next;
                alu_op_q   <= alu_op;
                gr_we_q    <= gr_we;
                is_load_q  <= is_load;
                is_store_q <= is_store;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == la_pkg::st_decode) begin
            inst_pc_q    <= pc;
            dest_q       <= dest;
            alu_src1     <= src1_is_pc ? pc : rf_rdata1;
            alu_src2     <= src2_is_imm ? imm : rf_rdata2;
            store_data_q <= rf_rdata2;
        end
        if (state == la_pkg::st_mem) begin
            mem_data_q <= data_sram_rdata;
        end
    end

    assign inst_sram_addr = pc;
    // decoder outputs only matter in decode
    assign decode_inst    = inst_sram_rdata;
    assign decode_pc      = pc;

    assign data_sram_we    = (state == la_pkg::st_exec) && is_store_q;
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = store_data_q;

    assign rf_we    = (state == la_pkg::st_wb) && gr_we_q;
    assign rf_waddr = dest_q;
    assign rf_wdata = is_load_q ? mem_data_q : alu_result;

    // trace mirrors the register write
    assign debug_wb_pc       = inst_pc_q;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

/* la_cpu_top.sv */
module la_cpu_top (
    input  logic             clk,
    input  logic             reset,
    input  la_pkg::word_t    inst_sram_rdata,
    input  la_pkg::word_t    data_sram_rdata,
    output la_pkg::word_t    inst_sram_addr,
    output logic             data_sram_we,
    output la_pkg::word_t    data_sram_addr,
    output la_pkg::word_t    data_sram_wdata,
    output la_pkg::word_t    debug_wb_pc,
    output logic [3:0]       debug_wb_rf_we,
    output la_pkg::reg_idx_t debug_wb_rf_wnum,
    output la_pkg::word_t    debug_wb_rf_wdata
);

    la_pkg::word_t    decode_inst;
    la_pkg::word_t    decode_pc;

    // decoder outputs
    la_pkg::alu_op_t  alu_op;
    la_pkg::reg_idx_t rf_raddr1;
    la_pkg::reg_idx_t rf_raddr2;
    la_pkg::reg_idx_t dest;
    logic             src1_is_pc;
    logic             src2_is_imm;
    la_pkg::word_t    imm;
    logic             is_load;
    logic             is_store;
    logic             gr_we;
    logic             is_cond_branch;
    logic             branch_on_eq;
    logic             is_jump;
    logic             is_jirl;
    la_pkg::word_t    branch_target_offs;

    la_pkg::word_t    rf_rdata1;
    la_pkg::word_t    rf_rdata2;
    logic             rf_we;
    la_pkg::reg_idx_t rf_waddr;
    la_pkg::word_t    rf_wdata;

    la_pkg::alu_op_t  alu_op_q;
    la_pkg::word_t    alu_src1;
    la_pkg::word_t    alu_src2;
    la_pkg::word_t    alu_result;

    la_control i_la_control (
        .clk, .reset,
        .inst_sram_rdata, .data_sram_rdata,
        .alu_op, .dest, .src1_is_pc, .src2_is_imm, .imm,
        .is_load, .is_store, .gr_we,
        .is_cond_branch, .branch_on_eq, .is_jump, .is_jirl, .branch_target_offs,
        .rf_rdata1, .rf_rdata2, .alu_result,
        .inst_sram_addr, .data_sram_we, .data_sram_addr, .data_sram_wdata,
        .decode_inst, .decode_pc,
        .alu_op_q, .alu_src1, .alu_src2,
        .rf_we, .rf_waddr, .rf_wdata,
        .debug_wb_pc, .debug_wb_rf_we, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

    la_decoder i_la_decoder (
        .inst (decode_inst),
        .pc   (decode_pc),
        .alu_op, .rf_raddr1, .rf_raddr2, .dest,
        .src1_is_pc, .src2_is_imm, .imm,
        .is_load, .is_store, .gr_we,
        .is_cond_branch, .branch_on_eq, .is_jump, .is_jirl, .branch_target_offs
    );

    la_regfile i_la_regfile (
        .clk,
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    la_alu i_la_alu (
        .alu_op (alu_op_q),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

endmodule

/* tb_sram_model.sv */
module tb_sram_model (
    input  logic          clk,
    input  la_pkg::word_t inst_addr,
    output la_pkg::word_t inst_rdata,
    input  logic          data_we,
    input  la_pkg::word_t data_addr,
    input  la_pkg::word_t data_wdata,
    output la_pkg::word_t data_rdata
);
    timeunit 1ns;
    timeprecision 100ps;

    la_pkg::word_t imem [256];
    la_pkg::word_t dmem [256];
    la_pkg::word_t inst_next;
    la_pkg::word_t data_next;
    int            n_words;
    int            seed = 32'he0a2_64a2;

    function automatic la_pkg::word_t enc_3r(logic [4:0] op, logic [4:0] rd, logic [4:0] rj,
                                             logic [4:0] rk);
        return {12'h001, op, rk, rj, rd};
    endfunction

    function automatic la_pkg::word_t enc_shift(logic [4:0] op, logic [4:0] rd, logic [4:0] rj,
                                                logic [4:0] ui5);
        return {12'h004, op, ui5, rj, rd};
    endfunction

    // addi.w, ld.w and st.w
    function automatic la_pkg::word_t enc_ri12(logic [9:0] op, logic [4:0] rd, logic [4:0] rj,
                                               logic [11:0] si12);
        return {op, si12, rj, rd};
    endfunction

    function automatic la_pkg::word_t enc_lu12i(logic [4:0] rd, logic [19:0] si20);
        return {7'h0a, si20, rd};
    endfunction

    // jirl, beq and bne; offset counted in words
    function automatic la_pkg::word_t enc_ri16(logic [5:0] op, logic [4:0] rd, logic [4:0] rj,
                                               logic [15:0] offs);
        return {op, offs, rj, rd};
    endfunction

    function automatic la_pkg::word_t enc_i26(logic [5:0] op, logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    task automatic emit(input la_pkg::word_t w);
        imem[n_words] = w;
        n_words++;
    endtask

    initial begin
        la_pkg::word_t v;
        inst_rdata = '0;
        data_rdata = '0;
        n_words    = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
            dmem[i] = '0;
        end
        for (int r = 4; r < 8; r++) begin
            v = $random(seed);
            v[11] = 1'b0;                 // addi must not borrow from the upper part
            if (r == 4) v[31] = 1'b1;     // mixed signs for slt and sltu
            if (r == 5) v[31] = 1'b0;
            emit(enc_lu12i(r[4:0], v[31:12]));
            emit(enc_ri12(10'h00a, r[4:0], r[4:0], v[11:0]));
        end
        emit(enc_3r(5'h00, 8, 4, 5));     // add.w
        emit(enc_3r(5'h02, 9, 4, 5));     // sub.w
        emit(enc_3r(5'h04, 10, 4, 5));
        emit(enc_3r(5'h05, 11, 4, 5));
        emit(enc_3r(5'h04, 12, 5, 4));
        emit(enc_3r(5'h05, 16, 5, 4));
        emit(enc_3r(5'h04, 17, 6, 7));
        emit(enc_3r(5'h08, 18, 4, 6));    // nor
        emit(enc_3r(5'h09, 19, 6, 7));
        emit(enc_3r(5'h0a, 20, 6, 7));
        emit(enc_3r(5'h0b, 21, 6, 7));
        emit(enc_shift(5'h01, 22, 4, 5'd31));
        emit(enc_shift(5'h09, 23, 4, 5'd31));
        emit(enc_shift(5'h11, 24, 4, 5'd31));
        emit(enc_shift(5'h11, 24, 4, v[4:0]));
        emit(enc_shift(5'h01, 3, 6, v[9:5]));
        emit(enc_shift(5'h09, 2, 7, 5'd0));
        // data at 0x100, stores then reloads
        emit(enc_ri12(10'h00a, 13, 0, 12'h100));
        emit(enc_ri12(10'h0a6, 8, 13, 12'h000));
        emit(enc_ri12(10'h0a6, 9, 13, 12'h004));
        emit(enc_ri12(10'h0a6, 4, 13, 12'hffc));
        emit(enc_ri12(10'h0a2, 14, 13, 12'h000));
        emit(enc_ri12(10'h0a2, 15, 13, 12'h004));
        emit(enc_ri12(10'h0a2, 25, 13, 12'h008));  // never written
        emit(enc_ri12(10'h0a2, 26, 13, 12'hffc));
        // each addi r27 below runs only if the branch before it falls through
        emit(enc_ri16(6'h16, 4, 4, 16'd2));        // beq taken
        emit(enc_ri12(10'h00a, 27, 27, 12'h001));
        emit(enc_ri16(6'h16, 5, 4, 16'd2));        // beq not taken
        emit(enc_ri12(10'h00a, 27, 27, 12'h002));
        emit(enc_ri16(6'h17, 5, 4, 16'd2));        // bne taken
        emit(enc_ri12(10'h00a, 27, 27, 12'h004));
        emit(enc_ri16(6'h17, 4, 4, 16'd2));        // bne not taken
        emit(enc_ri12(10'h00a, 27, 27, 12'h008));
        emit(enc_i26(6'h14, 26'd2));
        emit(enc_ri12(10'h00a, 27, 27, 12'h010));
        emit(enc_i26(6'h15, 26'd2));               // bl, r1 points at the next word
        emit(enc_ri12(10'h00a, 27, 27, 12'h020));
        emit(enc_ri16(6'h13, 28, 1, 16'd3));       // jirl lands two words further on
        emit(enc_ri12(10'h00a, 27, 27, 12'h040));
        emit(enc_ri12(10'h00a, 0, 4, 12'h005));    // write to r0
        emit(enc_3r(5'h00, 29, 0, 5));
        emit(enc_3r(5'h0a, 30, 0, 0));
        emit(enc_i26(6'h14, 26'd0));               // final loop
    end

    // read before write, results appear one cycle later
    always @(posedge clk) begin
        inst_next = imem[inst_addr[9:2]];
        data_next = dmem[data_addr[9:2]];
        if (data_we)
            dmem[data_addr[9:2]] = data_wdata;
        #1;
        inst_rdata = inst_next;
        data_rdata = data_next;
    end

endmodule

/* tb_cpu_top.sv */
`include "la_params.svh"

module tb_cpu_top;
    timeunit 1ns;
    timeprecision 100ps;

    logic             clk;
    logic             reset;
    la_pkg::word_t    inst_sram_rdata;
    la_pkg::word_t    data_sram_rdata;
    la_pkg::word_t    inst_sram_addr;
    logic             data_sram_we;
    la_pkg::word_t    data_sram_addr;
    la_pkg::word_t    data_sram_wdata;
    la_pkg::word_t    debug_wb_pc;
    logic [3:0]       debug_wb_rf_we;
    la_pkg::reg_idx_t debug_wb_rf_wnum;
    la_pkg::word_t    debug_wb_rf_wdata;

    // expected trace and stores from the instruction-set model
    la_pkg::word_t    exp_pc_q [$];
    la_pkg::reg_idx_t exp_num_q [$];
    la_pkg::word_t    exp_data_q [$];
    int               exp_cyc_q [$];
    la_pkg::word_t    st_addr_q [$];
    la_pkg::word_t    st_data_q [$];
    la_pkg::word_t    model_regs [32];
    la_pkg::word_t    model_mem [la_pkg::word_t];
    la_pkg::word_t    loop_pc = '1;
    int               n_exec = 0;
    bit               model_ready = 1'b0;

    int               cycle = 0;
    bit               seen_trace = 1'b0;
    int               first_cyc;
    int               first_exp;
    int               value_errs = 0;
    int               other_errs = 0;

    la_cpu_top i_la_cpu_top (
        .clk, .reset, .inst_sram_rdata, .data_sram_rdata,
        .inst_sram_addr, .data_sram_we, .data_sram_addr, .data_sram_wdata,
        .debug_wb_pc, .debug_wb_rf_we, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

    tb_sram_model i_sram (
        .clk,
        .inst_addr  (inst_sram_addr),
        .inst_rdata (inst_sram_rdata),
        .data_we    (data_sram_we),
        .data_addr  (data_sram_addr),
        .data_wdata (data_sram_wdata),
        .data_rdata (data_sram_rdata)
    );

    task automatic fail_value(input string name, input la_pkg::word_t expected,
                              input la_pkg::word_t actual);
        value_errs++;
        $display("Fail %s: expected %h, actual %h", name, expected, actual);
    endtask

    task automatic report_and_finish();
        $display("errors: %0d wrong values, %0d other", value_errs, other_errs);
        if (value_errs + other_errs == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    endtask

    // sequential run of the program; cycle counts per instruction class
    task automatic run_model();
        la_pkg::word_t    pc;
        la_pkg::word_t    npc;
        la_pkg::word_t    w;
        la_pkg::word_t    a;
        la_pkg::word_t    b;
        la_pkg::word_t    d;
        la_pkg::word_t    res;
        la_pkg::word_t    addr;
        la_pkg::word_t    offs16;
        la_pkg::word_t    offs26;
        la_pkg::reg_idx_t rd;
        int               len;
        int               cyc;
        bit               wr;
        bit               done;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        pc   = `LA_RESET_PC;
        cyc  = 0;
        done = 1'b0;
        while (!done && n_exec < 1000) begin
            w      = i_sram.imem[pc[9:2]];
            rd     = w[4:0];
            a      = model_regs[w[9:5]];
            b      = model_regs[w[14:10]];
            d      = model_regs[w[4:0]];
            addr   = a + {{20{w[21]}}, w[21:10]};
            offs16 = {{14{w[25]}}, w[25:10], 2'b00};
            offs26 = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
            npc    = pc + 32'd4;
            res    = '0;
            len    = 4;
            wr     = 1'b1;
            if (w[31:20] == 12'h001) begin
                case (w[19:15])
                    5'h00:   res = a + b;
                    5'h02:   res = a - b;
                    5'h04:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    5'h05:   res = (a < b) ? 32'd1 : 32'd0;
                    5'h08:   res = ~(a | b);
                    5'h09:   res = a & b;
                    5'h0a:   res = a | b;
                    5'h0b:   res = a ^ b;
                    default: res = '0;
                endcase
            end else if (w[31:20] == 12'h004) begin
                case (w[19:15])
                    5'h01:   res = a << w[14:10];
                    5'h09:   res = a >> w[14:10];
                    5'h11:   res = $signed(a) >>> w[14:10];
                    default: res = '0;
                endcase
            end else if (w[31:22] == 10'h00a) begin
                res = addr;                                // addi.w
            end else if (w[31:25] == 7'h0a) begin
                res = {w[24:5], 12'h000};
            end else if (w[31:22] == 10'h0a2) begin
                res = model_mem.exists(addr) ? model_mem[addr] : '0;
                len = 5;
            end else if (w[31:22] == 10'h0a6) begin
                model_mem[addr] = d;
                st_addr_q.push_back(addr);
                st_data_q.push_back(d);
                len = 3;
                wr  = 1'b0;
            end else if (w[31:26] == 6'h13) begin
                res = pc + 32'd4;                          // jirl
                npc = a + offs16;
            end else if (w[31:27] == 5'b01010) begin
                npc = pc + offs26;                         // b or bl
                if (w[26]) begin
                    rd  = 5'd1;
                    res = pc + 32'd4;
                end else begin
                    wr   = 1'b0;
                    len  = 2;
                    done = (offs26 == '0);
                end
            end else if (w[31:27] == 5'b01011) begin
                wr  = 1'b0;                                // beq or bne
                len = 2;
                if ((a == d) != w[26])
                    npc = pc + offs16;
            end else begin
                other_errs++;
                $display("model met the unknown instruction %h at %h", w, pc);
                done = 1'b1;
            end
            if (done) begin
                loop_pc = pc;
            end else begin
                if (wr) begin
                    exp_pc_q.push_back(pc);
                    exp_num_q.push_back(rd);
                    exp_data_q.push_back(res);
                    exp_cyc_q.push_back(cyc + len - 1);
                    if (rd != 5'd0)
                        model_regs[rd] = res;
                end
                cyc += len;
                n_exec++;
                pc = npc;
            end
        end
    endtask

    task automatic check_outputs();
        la_pkg::word_t    e_pc;
        la_pkg::word_t    e_data;
        la_pkg::word_t    e_addr;
        la_pkg::reg_idx_t e_num;
        int               e_cyc;
        assert (debug_wb_rf_we == 4'h0 || debug_wb_rf_we == 4'hf) else begin
            other_errs++;
            $display("trace write enable %b is neither all low nor all high", debug_wb_rf_we);
        end
        if (!seen_trace) begin
            assert (!data_sram_we) else begin
                other_errs++;
                $display("data SRAM written before the first register write");
            end
        end
        if (data_sram_we) begin
            if (st_addr_q.size() == 0) begin
                other_errs++;
                $display("data SRAM write to %h that the model does not expect", data_sram_addr);
            end else begin
                e_addr = st_addr_q.pop_front();
                e_data = st_data_q.pop_front();
                assert (data_sram_addr == e_addr) else fail_value("store addr", e_addr, data_sram_addr);
                assert (data_sram_wdata == e_data) else fail_value("store data", e_data, data_sram_wdata);
            end
        end
        if (debug_wb_rf_we == 4'hf) begin
            if (exp_pc_q.size() == 0) begin
                other_errs++;
                $display("trace entry at pc %h after the last expected one", debug_wb_pc);
            end else begin
                e_pc   = exp_pc_q.pop_front();
                e_num  = exp_num_q.pop_front();
                e_data = exp_data_q.pop_front();
                e_cyc  = exp_cyc_q.pop_front();
                if (!seen_trace) begin
                    first_cyc  = cycle;
                    first_exp  = e_cyc;
                    seen_trace = 1'b1;
                    assert (debug_wb_pc == `LA_RESET_PC)
                        else fail_value("first trace pc", `LA_RESET_PC, debug_wb_pc);
                end
                assert (debug_wb_pc == e_pc) else fail_value("trace pc", e_pc, debug_wb_pc);
                assert (debug_wb_rf_wnum == e_num)
                    else fail_value("trace wnum", {27'b0, e_num}, {27'b0, debug_wb_rf_wnum});
                assert (debug_wb_rf_wdata == e_data)
                    else fail_value("trace wdata", e_data, debug_wb_rf_wdata);
                assert (cycle - first_cyc == e_cyc - first_exp)
                    else fail_value("retire cycle", e_cyc - first_exp, cycle - first_cyc);
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
        cycle++;

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (cycle > 0)
            check_outputs();
    end

    initial begin
        reset = 1'b1;
        #1;
        run_model();   // program is in place by now
        model_ready = 1'b1;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        while (!(exp_pc_q.size() == 0 && inst_sram_addr == loop_pc))
            @(negedge clk);
        repeat (8) @(negedge clk);   // nothing more may retire
        if (st_addr_q.size() != 0) begin
            other_errs++;
            $display("%0d stores of the model never reached the data SRAM", st_addr_q.size());
        end
        report_and_finish();
    end

    // watchdog, 6 cycles per executed instruction plus a margin
    initial begin
        wait (model_ready);
        repeat (6 * n_exec + 40) @(posedge clk);
        other_errs++;
        $display("watchdog: the run did not reach the final loop in time");
        report_and_finish();
    end

endmodule

/* sim.f */
+incdir+.
la_pkg.sv
la_decoder.sv
la_alu.sv
la_regfile.sv
la_control.sv
la_cpu_top.sv
tb_sram_model.sv
tb_cpu_top.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/1ps --top-module tb_cpu_top -f sim.f \
    -o tb_cpu_top > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_cpu_top > sim.log 2>&1 || { cat sim.log; echo "simulation error"; exit 1; }
cat sim.log
grep -q "Regression passed" sim.log && exit 0 || exit 1
